//--- project.f
hw/piano_pkg.sv
hw/key_event_if.sv
hw/ps2_rx.sv
hw/key_decoder.sv
hw/note_sequencer.sv
hw/tone_gen.sv
hw/piano_top.sv
tb/piano_tb.sv

//--- tb/piano_tb.sv
// *********************************************************
// Directed testbench of the PS/2 scale player
// PS/2 keyboard model, tone period measurement, compare tasks
// *********************************************************
`default_nettype none
`timescale 1ns/10ps

module piano_tb;

    localparam int CLK_HZ      = 1_000_000;
    localparam int STEP_CYCLES = 20_000;
    localparam int IDLE_CYCLES = 2_000;
    localparam int HALF_BIT    = 40;        // Clock cycles per PS/2 half bit
    localparam int PWM_TIMEOUT = 10_000;
    localparam int POS_TOP     = 28;        // Do of octave 8

    logic                   clk;
    logic                   rst;
    logic                   ps2_clk;
    logic                   ps2_data;
    logic                   audio_pwm;
    logic                   amp_shutdown_n;
    piano_pkg::tone_t       note_tone;
    piano_pkg::octave_t     note_octave;

    int pos;          // Expected note position from Do of octave 4
    int slow_gap;

    piano_top #(
        .CLK_HZ      (CLK_HZ),
        .STEP_CYCLES (STEP_CYCLES),
        .IDLE_CYCLES (IDLE_CYCLES)
    ) dut (
        .clk            (clk),
        .rst            (rst),
        .ps2_clk        (ps2_clk),
        .ps2_data       (ps2_data),
        .audio_pwm      (audio_pwm),
        .amp_shutdown_n (amp_shutdown_n),
        .note_tone      (note_tone),
        .note_octave    (note_octave)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // *********************************************************
    // Reference model and compare tasks
    // *********************************************************
    function automatic piano_pkg::tone_t tone_of(input int p);
        return piano_pkg::tone_t'(p % 7);
    endfunction

    function automatic piano_pkg::octave_t octave_of(input int p);
        return piano_pkg::octave_t'(piano_pkg::OCTAVE_MIN + p / 7);
    endfunction

    function automatic int expected_period(input piano_pkg::tone_t t,
                                           input piano_pkg::octave_t o);
        return (CLK_HZ / piano_pkg::base_freq(t)) >> (o - piano_pkg::OCTAVE_MIN);
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic check_note(input string name, input piano_pkg::tone_t exp_tone,
                              input piano_pkg::octave_t exp_oct);
        if (note_tone !== exp_tone || note_octave !== exp_oct) begin
            $display("** Error %s: expected tone %0d octave %0d, actual tone %0d octave %0d",
                     name, exp_tone, exp_oct, note_tone, note_octave);
            abort_run("Note outputs mismatch");
        end
    endtask

    task automatic check_period(input string name, input int exp_cycles, input int act_cycles);
        if (exp_cycles != act_cycles) begin
            $display("** Error %s: expected %0d cycles, actual %0d cycles",
                     name, exp_cycles, act_cycles);
            abort_run("Cycle count mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic exp_bit, input logic act_bit);
        if (exp_bit !== act_bit) begin
            $display("** Error %s: expected %b, actual %b", name, exp_bit, act_bit);
            abort_run("Bit mismatch");
        end
    endtask

    // *********************************************************
    // PS/2 keyboard model
    // *********************************************************
    task automatic send_byte(input piano_pkg::scan_code_t code, input bit bad_parity);
        logic [10:0] frame;
        frame = {1'b1, (~^code) ^ bad_parity, code, 1'b0};   // Stop, odd parity, data, start
        for (int i = 0; i < 11; i++) begin
            @(posedge clk);
            ps2_data <= frame[i];
            repeat (HALF_BIT) @(posedge clk);
            ps2_clk <= 1'b0;
            repeat (HALF_BIT) @(posedge clk);
            ps2_clk <= 1'b1;
        end
        repeat (4 * HALF_BIT) @(posedge clk);   // Gap between frames
    endtask

    task automatic press_key(input piano_pkg::scan_code_t code, input bit extended);
        if (extended) send_byte(piano_pkg::CODE_EXTEND, 1'b0);
        send_byte(code, 1'b0);
    endtask

    task automatic release_key(input piano_pkg::scan_code_t code, input bit extended);
        if (extended) send_byte(piano_pkg::CODE_EXTEND, 1'b0);
        send_byte(piano_pkg::CODE_BREAK, 1'b0);
        send_byte(code, 1'b0);
    endtask

    // *********************************************************
    // Output watchers
    // *********************************************************
    // Cycles up to the next rising edge of audio_pwm, and high cycles among them
    task automatic pwm_rise_gap(output int cycles, output int high_cycles);
        logic prev;
        logic rose;
        cycles      = 0;
        high_cycles = 0;
        rose        = 1'b0;
        prev        = audio_pwm;
        while (!rose) begin
            @(negedge clk);
            cycles++;
            if (audio_pwm) high_cycles++;
            rose = !prev && audio_pwm;
            prev = audio_pwm;
            if (cycles > PWM_TIMEOUT) begin
                abort_run("Timed out waiting for a rising edge of audio_pwm");
            end
        end
    endtask

    task automatic measure_period(output int period, output int high_time);
        int skip_p;
        int skip_h;
        pwm_rise_gap(skip_p, skip_h);     // Sync to a period boundary
        pwm_rise_gap(period, high_time);
    endtask

    task automatic wait_note(output int gap);
        piano_pkg::tone_t   t0;
        piano_pkg::octave_t o0;
        @(negedge clk);
        t0  = note_tone;
        o0  = note_octave;
        gap = 0;
        while (note_tone == t0 && note_octave == o0) begin
            @(negedge clk);
            gap++;
            if (gap > 3 * STEP_CYCLES) begin
                abort_run("Timed out waiting for the note outputs to change");
            end
        end
    endtask

    task automatic step_and_check(input string name, input bit up, output int gap);
        wait_note(gap);
        if (up) pos = (pos < POS_TOP) ? pos + 1 : POS_TOP;
        else    pos = (pos > 0) ? pos - 1 : 0;
        check_note(name, tone_of(pos), octave_of(pos));
    endtask

    task automatic hold_note(input string name, input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_note(name, tone_of(pos), octave_of(pos));
        end
    endtask

    task automatic check_pitch(input string name);
        int period;
        int high_time;
        int exp_p;
        exp_p = expected_period(tone_of(pos), octave_of(pos));
        measure_period(period, high_time);
        check_period({name, " period"}, exp_p, period);
        check_period({name, " high time"}, exp_p >> 1, high_time);
    endtask

    // *********************************************************
    // Tests
    // *********************************************************
    task automatic test_reset_state();
        check_bit("reset amp_shutdown_n", 1'b0, amp_shutdown_n);
        check_bit("reset audio_pwm", 1'b0, audio_pwm);
        check_note("reset note", 3'd0, piano_pkg::OCTAVE_MIN);
    endtask

    task automatic test_reset_init();
        piano_pkg::scan_code_t code;
        repeat (3) begin
            code = piano_pkg::CODE_INIT;
            while (code == piano_pkg::CODE_INIT) code = piano_pkg::scan_code_t'($urandom);
            send_byte(code, 1'b0);
            check_bit("filler before init", 1'b0, amp_shutdown_n);
        end
        send_byte(piano_pkg::CODE_INIT, 1'b0);
        check_bit("init code", 1'b1, amp_shutdown_n);
    endtask

    task automatic test_pitch();
        press_key(piano_pkg::KEY_ENTER, 1'b0);
        pos = 0;
        hold_note("enter held", 2 * STEP_CYCLES);   // Longer than one step interval
        check_pitch("enter held Do 4");
    endtask

    task automatic test_step_up();
        int gap;
        int k;
        k = $urandom_range(4, 1);
        release_key(piano_pkg::KEY_ENTER, 1'b0);
        for (int i = 1; i <= 4; i++) begin
            step_and_check("step up", 1'b1, gap);
            if (i == k) check_pitch("random note");
        end
        send_byte(piano_pkg::KEY_S, 1'b1);    // Corrupted parity
        step_and_check("bad parity S", 1'b1, gap);
        press_key(piano_pkg::KEY_S, 1'b1);
        release_key(piano_pkg::KEY_S, 1'b1);
        step_and_check("extended S", 1'b1, gap);
        step_and_check("octave wrap up", 1'b1, gap);
    endtask

    task automatic test_step_down();
        int gap;
        press_key(piano_pkg::KEY_S, 1'b0);
        release_key(piano_pkg::KEY_S, 1'b0);
        step_and_check("step down", 1'b0, gap);
        release_key(piano_pkg::KEY_W, 1'b0);   // Break of W only
        while (pos > 0) step_and_check("step down after W break", 1'b0, gap);
        slow_gap = gap;
        hold_note("bottom saturation", 5 * STEP_CYCLES / 2);
    endtask

    task automatic test_fast_rate();
        int gap;
        press_key(piano_pkg::KEY_W, 1'b0);
        release_key(piano_pkg::KEY_W, 1'b0);
        step_and_check("W back up", 1'b1, gap);
        press_key(piano_pkg::KEY_R, 1'b0);
        release_key(piano_pkg::KEY_R, 1'b0);
        step_and_check("fast step", 1'b1, gap);
        step_and_check("fast step", 1'b1, gap);
        check_bit("fast gap below 3/4 slow", 1'b1, gap * 4 < slow_gap * 3);
        press_key(piano_pkg::KEY_R, 1'b0);
        release_key(piano_pkg::KEY_R, 1'b0);
        step_and_check("slow again", 1'b1, gap);
        step_and_check("slow again", 1'b1, gap);
        check_bit("slow gap restored", 1'b1, gap * 4 >= slow_gap * 3);
    endtask

    task automatic test_upper_limit();
        int gap;
        while (pos < POS_TOP) step_and_check("climb to top", 1'b1, gap);
        hold_note("top saturation", 5 * STEP_CYCLES / 2);
        check_pitch("Do 8");
        press_key(piano_pkg::KEY_ENTER, 1'b0);
        pos = 0;
        check_note("enter from top", 3'd0, piano_pkg::OCTAVE_MIN);
    endtask

    initial begin
        rst      = 1'b1;
        ps2_clk  = 1'b1;
        ps2_data = 1'b1;
        pos      = 0;
        slow_gap = STEP_CYCLES;
        void'($urandom(3));
        repeat (7) @(posedge clk);
        @(negedge clk);
        test_reset_state();                   // Still in reset
        @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        test_reset_init();
        test_pitch();
        test_step_up();
        test_step_down();
        test_fast_rate();
        test_upper_limit();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/piano_top.sv
// *********************************************************
// Scale player top level
// PS/2 receiver, key decoder, note sequencer, tone generator
// *********************************************************
`default_nettype none
`timescale 1ns/10ps

module piano_top #(
    parameter int CLK_HZ      = 100_000_000,
    parameter int STEP_CYCLES = 100_000_000,
    parameter int IDLE_CYCLES = 100_000
) (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               ps2_clk,
    input  wire logic               ps2_data,
    output logic                    audio_pwm,
    output logic                    amp_shutdown_n,   // Muted until keyboard is up
    output piano_pkg::tone_t        note_tone,
    output piano_pkg::octave_t      note_octave
);

    logic                   byte_valid;
    piano_pkg::scan_code_t  byte_data;

    key_event_if key_evt ();

    ps2_rx #(
        .IDLE_CYCLES (IDLE_CYCLES)
    ) u_ps2_rx (
        .clk        (clk),
        .rst        (rst),
        .ps2_clk    (ps2_clk),
        .ps2_data   (ps2_data),
        .byte_valid (byte_valid),
        .byte_data  (byte_data)
    );

    key_decoder u_key_decoder (
        .clk        (clk),
        .rst        (rst),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .evt        (key_evt.source),
        .kbd_ready  (amp_shutdown_n)
    );

    note_sequencer #(
        .STEP_CYCLES (STEP_CYCLES)
    ) u_note_sequencer (
        .clk         (clk),
        .rst         (rst),
        .evt         (key_evt.sink),
        .note_tone   (note_tone),
        .note_octave (note_octave)
    );

    tone_gen #(
        .CLK_HZ (CLK_HZ)
    ) u_tone_gen (
        .clk         (clk),
        .rst         (rst),
        .note_tone   (note_tone),
        .note_octave (note_octave),
        .audio_pwm   (audio_pwm)
    );

endmodule

`default_nettype wire

//--- hw/tone_gen.sv
// *********************************************************
// Square-wave tone generator
// Per-tone period table built at elaboration, 50 % duty output
// *********************************************************
`default_nettype none
`timescale 1ns/10ps

module tone_gen #(
    parameter int CLK_HZ = 100_000_000
) (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire piano_pkg::tone_t       note_tone,
    input  wire piano_pkg::octave_t     note_octave,
    output logic                        audio_pwm
);

    // Longest period belongs to Do of octave 4
    localparam int PW = $clog2(CLK_HZ / piano_pkg::base_freq(3'd0) + 1);

    typedef logic [PW-1:0] period_t;

    // Octave-4 periods in clock cycles
    localparam period_t PERIOD_TAB [7] = '{
        period_t'(CLK_HZ / piano_pkg::base_freq(3'd0)),
        period_t'(CLK_HZ / piano_pkg::base_freq(3'd1)),
        period_t'(CLK_HZ / piano_pkg::base_freq(3'd2)),
        period_t'(CLK_HZ / piano_pkg::base_freq(3'd3)),
        period_t'(CLK_HZ / piano_pkg::base_freq(3'd4)),
        period_t'(CLK_HZ / piano_pkg::base_freq(3'd5)),
        period_t'(CLK_HZ / piano_pkg::base_freq(3'd6))
    };

    piano_pkg::tone_t   tone_idx;
    period_t            period_next;
    period_t            period_q;     // Period now playing
    period_t            cnt;

    assign tone_idx    = (note_tone > 3'd6) ? 3'd0 : note_tone;
    assign period_next = PERIOD_TAB[tone_idx] >> (note_octave - piano_pkg::OCTAVE_MIN);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt       <= '0;
            period_q  <= PERIOD_TAB[0];
            audio_pwm <= 1'b0;
        end else if (cnt >= period_q - 1'b1) begin
            cnt       <= '0;
            period_q  <= period_next;   // Note change lands on a boundary
            audio_pwm <= 1'b1;
        end else begin
            cnt       <= cnt + 1'b1;
            audio_pwm <= (cnt + 1'b1) < (period_q >> 1);  // High for first half
        end
    end

endmodule

`default_nettype wire

//--- hw/note_sequencer.sv
// *********************************************************
// Note sequencer
// Key handling for Enter, W, S and R plus the timed note stepper
// *********************************************************
`default_nettype none
`timescale 1ns/10ps

module note_sequencer #(
    parameter int STEP_CYCLES = 100_000_000
) (
    input  wire logic               clk,
    input  wire logic               rst,
    key_event_if.sink               evt,
    output piano_pkg::tone_t        note_tone,
    output piano_pkg::octave_t      note_octave
);

    localparam int TW = $clog2(STEP_CYCLES);

    logic           enter_held;
    logic           dir_up;
    logic           fast;
    logic [TW-1:0]  timer;
    logic [TW-1:0]  timer_last;
    logic           step;
    logic           plain_key;

    assign plain_key  = evt.valid && !evt.extend;   // E0 keys are ignored
    assign timer_last = fast ? TW'(STEP_CYCLES / 2 - 1) : TW'(STEP_CYCLES - 1);
    assign step       = (timer >= timer_last);      // Also catches a late fast switch

    // *********************************************************
    // Key events
    // *********************************************************
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            enter_held <= 1'b0;
            dir_up     <= 1'b1;
            fast       <= 1'b0;
        end else if (plain_key) begin
            case (evt.code)
                piano_pkg::KEY_ENTER: enter_held <= !evt.released;
                piano_pkg::KEY_W: begin
                    if (!evt.released) dir_up <= 1'b1;
                end
                piano_pkg::KEY_S: begin
                    if (!evt.released) dir_up <= 1'b0;
                end
                piano_pkg::KEY_R: begin
                    if (!evt.released) fast <= ~fast;
                end
                default: ;
            endcase
        end
    end

    // *********************************************************
    // Step timer and note position
    // Position runs from Do of octave 4 to Do of octave 8
    // *********************************************************
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            timer       <= '0;
            note_tone   <= 3'd0;
            note_octave <= piano_pkg::OCTAVE_MIN;
        end else if (enter_held) begin
            timer       <= '0;                      // Parked on Do 4
            note_tone   <= 3'd0;
            note_octave <= piano_pkg::OCTAVE_MIN;
        end else if (step) begin
            timer <= '0;
            if (dir_up) begin
                if (note_octave == piano_pkg::OCTAVE_MAX) begin
                    note_tone <= note_tone;         // Top end, hold
                end else if (note_tone == 3'd6) begin
                    note_tone   <= 3'd0;            // Si to next Do
                    note_octave <= note_octave + 4'd1;
                end else begin
                    note_tone <= note_tone + 3'd1;
                end
            end else begin
                if (note_tone == 3'd0 && note_octave == piano_pkg::OCTAVE_MIN) begin
                    note_tone <= note_tone;         // Bottom end, hold
                end else if (note_tone == 3'd0) begin
                    note_tone   <= 3'd6;            // Do to Si below
                    note_octave <= note_octave - 4'd1;
                end else begin
                    note_tone <= note_tone - 3'd1;
                end
            end
        end else begin
            timer <= timer + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- hw/key_decoder.sv
// *********************************************************
// Scan-code decoder
// Waits for keyboard self-test code, strips E0 and F0 prefixes
// *********************************************************
`default_nettype none
`timescale 1ns/10ps

module key_decoder (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   byte_valid,
    input  wire piano_pkg::scan_code_t  byte_data,
    key_event_if.source                 evt,
    output logic                        kbd_ready
);

    typedef enum logic {
        ST_WAIT_INIT,
        ST_IDLE
    } state_t;

    state_t state;
    logic   extend_q;     // E0 seen
    logic   release_q;    // F0 seen
    logic   is_prefix;
    logic   key_byte;

    assign is_prefix = (byte_data == piano_pkg::CODE_EXTEND) ||
                       (byte_data == piano_pkg::CODE_BREAK);

    // Final byte of a key code, self-test code is not a key
    assign key_byte = byte_valid && (state == ST_IDLE) && !is_prefix &&
                      (byte_data != piano_pkg::CODE_INIT);

    assign kbd_ready = (state == ST_IDLE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= ST_WAIT_INIT;
            extend_q  <= 1'b0;
            release_q <= 1'b0;
            evt.valid <= 1'b0;
        end else begin
            evt.valid <= key_byte;
            if (byte_valid) begin
                case (state)
                    ST_WAIT_INIT: begin
                        if (byte_data == piano_pkg::CODE_INIT) begin
                            state <= ST_IDLE;     // Keyboard announced itself
                        end
                    end
                    default: begin
                        if (byte_data == piano_pkg::CODE_EXTEND) begin
                            extend_q <= 1'b1;
                        end else if (byte_data == piano_pkg::CODE_BREAK) begin
                            release_q <= 1'b1;
                        end else begin
                            extend_q  <= 1'b0;    // Code done, drop prefixes
                            release_q <= 1'b0;
                        end
                    end
                endcase
            end
        end
    end

    // Event payload
    always_ff @(posedge clk) begin
        if (key_byte) begin
            evt.code     <= byte_data;
            evt.extend   <= extend_q;
            evt.released <= release_q;
        end
    end

endmodule

`default_nettype wire

//--- hw/ps2_rx.sv
// *********************************************************
// PS/2 receiver, device to host direction only
// Line synchroniser, frame shifter, frame checks, idle timeout
// *********************************************************
`default_nettype none
`timescale 1ns/10ps

module ps2_rx #(
    parameter int IDLE_CYCLES = 2000
) (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   ps2_clk,
    input  wire logic                   ps2_data,
    output logic                        byte_valid,
    output piano_pkg::scan_code_t       byte_data
);

    localparam int IW = $clog2(IDLE_CYCLES + 1);

    logic [1:0]     clk_sync;     // Two-flop synchroniser
    logic [1:0]     data_sync;
    logic           clk_prev;
    logic           clk_fall;

    logic [10:0]    frame;        // {stop, parity, data[7:0], start}
    logic [3:0]     bit_cnt;
    logic [IW-1:0]  idle_cnt;
    logic           frame_full;
    logic           frame_ok;

    // *********************************************************
    // Synchronise and find falling edges of the PS/2 clock
    // *********************************************************
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            clk_sync  <= 2'b11;   // Both lines idle high
            data_sync <= 2'b11;
            clk_prev  <= 1'b1;
        end else begin
            clk_sync  <= {clk_sync[0], ps2_clk};
            data_sync <= {data_sync[0], ps2_data};
            clk_prev  <= clk_sync[1];
        end
    end

    assign clk_fall = clk_prev & ~clk_sync[1];

    // Start low, stop high, odd parity over data and parity bit
    assign frame_ok = ~frame[0] & frame[10] & (^frame[9:1]);

    // *********************************************************
    // Bit counter, idle timeout and frame completion
    // *********************************************************
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bit_cnt    <= '0;
            idle_cnt   <= '0;
            frame_full <= 1'b0;
            byte_valid <= 1'b0;
        end else begin
            frame_full <= 1'b0;
            byte_valid <= frame_full & frame_ok;
            if (clk_fall) begin
                bit_cnt  <= bit_cnt + 4'd1;
                idle_cnt <= '0;
            end else if (bit_cnt == 4'd11) begin
                bit_cnt    <= '0;     // Whole frame in, check next cycle
                frame_full <= 1'b1;
            end else if (bit_cnt != 4'd0) begin
                if (idle_cnt == IW'(IDLE_CYCLES - 1)) begin
                    bit_cnt  <= '0;   // Keyboard went quiet mid-frame
                    idle_cnt <= '0;
                end else begin
                    idle_cnt <= idle_cnt + 1'b1;
                end
            end
        end
    end

    // Frame and byte payload
    always_ff @(posedge clk) begin
        if (clk_fall) begin
            frame <= {data_sync[1], frame[10:1]};  // LSB arrives first
        end
        if (frame_full) begin
            byte_data <= frame[8:1];
        end
    end

endmodule

`default_nettype wire

//--- hw/key_event_if.sv
// *********************************************************
// Key event bundle from scan-code decoder to note sequencer
// *********************************************************
`default_nettype none
`timescale 1ns/10ps

interface key_event_if;

    logic                   valid;     // One-cycle strobe
    piano_pkg::scan_code_t  code;      // Make code, prefixes stripped
    logic                   extend;    // Code came after E0
    logic                   released;  // Code came after F0, key let go

    modport source (
        output valid, code, extend, released
    );

    modport sink (
        input valid, code, extend, released
    );

endinterface

`default_nettype wire

//--- hw/piano_pkg.sv
// *********************************************************
// Shared types and constants of the PS/2 scale player
// Scan codes, note index types and the octave-4 frequency table
// *********************************************************
`default_nettype none

package piano_pkg;

    // *********************************************************
    // Keyboard codes, scan code set 2
    // *********************************************************
    typedef logic [7:0] scan_code_t;

    localparam scan_code_t KEY_W       = 8'h1D;
    localparam scan_code_t KEY_S       = 8'h1B;
    localparam scan_code_t KEY_R       = 8'h2D;
    localparam scan_code_t KEY_ENTER   = 8'h5A;

    localparam scan_code_t CODE_INIT   = 8'hAA;  // Self-test passed
    localparam scan_code_t CODE_EXTEND = 8'hE0;
    localparam scan_code_t CODE_BREAK  = 8'hF0;

    // *********************************************************
    // Notes
    // *********************************************************
    typedef logic [2:0] tone_t;    // 0 Do .. 6 Si
    typedef logic [3:0] octave_t;

    localparam octave_t OCTAVE_MIN = 4'd4;
    localparam octave_t OCTAVE_MAX = 4'd8;

    // Octave-4 frequency in Hz, rounded
    function automatic int unsigned base_freq(input tone_t tone);
        case (tone)
            3'd0:    return 262;  // Do
            3'd1:    return 294;  // Re
            3'd2:    return 330;  // Mi
            3'd3:    return 349;  // Fa
            3'd4:    return 392;  // Sol
            3'd5:    return 440;  // La
            3'd6:    return 494;  // Si
            default: return 262;
        endcase
    endfunction

endpackage

`default_nettype wire
